// File: sim.f
source/tcp_rx_pkg.sv
source/tcp_seg_dispatch.sv
source/tcp_hdr_parser.sv
source/tcp_result_collect.sv
source/tcp_rx_top.sv
verif/tcp_rx_tb.sv

// File: Bender.yml
package:
  name: tcp_rx

sources:
  - files:
      - source/tcp_rx_pkg.sv
      - source/tcp_seg_dispatch.sv
      - source/tcp_hdr_parser.sv
      - source/tcp_result_collect.sv
      - source/tcp_rx_top.sv
  - target: test
    files:
      - verif/tcp_rx_tb.sv

vendor_package: []

frozen: false

// File: verif/tcp_rx_tb.sv
`timescale 1ns/100ps
`default_nettype none

module tcp_rx_tb;
  import tcp_rx_pkg::*;

  localparam int          N_MIXED    = 40;
  localparam int          N_FILL     = 12;
  localparam int          N_SEG      = N_MIXED + N_FILL;
  localparam logic [15:0] LOCAL_PORT = 16'h1f90;

  // fields chosen for one generated segment
  typedef struct packed {
    logic [15:0] src_port;
    logic [15:0] dst_port;
    logic [31:0] seq_num;
    logic [31:0] ack_num;
    logic [8:0]  flags;
    logic [15:0] win_size;
    logic [3:0]  offset;
    logic [15:0] stated_len;
    logic        mss_en;
    logic [15:0] mss;
    logic        ws_en;
    logic [7:0]  ws;
    logic        sperm_en;
    logic        sack_en;
    logic [2:0]  sack_n;
    logic        ts_en;
    logic [31:0] ts_val;
    logic [31:0] ts_echo;
    logic        len_err;
    logic        bit_err;
    logic [15:0] err_pos;
  } seg_gen_t;

  logic          clk;
  logic          fsm_rst;
  tcp_byte_t     in_beat;
  logic          in_valid;
  logic [15:0]   local_port;
  logic          out_ack;
  logic          in_ready;
  tcp_seg_info_t out_info;
  logic          out_req;

  logic [15:0]   lfsr;
  logic [15:0]   ack_lfsr;
  logic [7:0]    seg_q [$];
  tcp_seg_info_t exp_q [$];
  logic          slow_ack;
  int            stall_cnt;
  int            n_checked;

  tcp_rx_top dut (
    .clk        (clk),
    .fsm_rst    (fsm_rst),
    .in_beat    (in_beat),
    .in_valid   (in_valid),
    .local_port (local_port),
    .out_ack    (out_ack),
    .in_ready   (in_ready),
    .out_info   (out_info),
    .out_req    (out_req)
  );

  always #2 clk = ~clk;

  // one galois lfsr step
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  // stimulus bits, one lfsr step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // ack delay bits from a separate lfsr state
  function automatic logic [31:0] ack_delay_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      ack_lfsr = lfsr_step(ack_lfsr);
      v        = {v[30:0], ack_lfsr[0]};
    end
    return v;
  endfunction

  task automatic check_field(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      $display("Finished with errors");
      $fatal(1);
    end
  endtask

  // expected result straight from the generated fields
  function automatic tcp_seg_info_t expect_info(input seg_gen_t g);
    tcp_seg_info_t e;
    e                = '0;
    e.src_port       = g.src_port;
    e.dst_port       = g.dst_port;
    e.seq_num        = g.seq_num;
    e.ack_num        = g.ack_num;
    e.flags          = g.flags;
    e.win_size       = g.win_size;
    e.hdr_len        = {g.offset, 2'b00};
    e.payload_len    = g.stated_len - {10'd0, g.offset, 2'b00};
    e.mss_pres       = g.mss_en;
    e.mss            = g.mss;
    e.wscale_pres    = g.ws_en;
    e.wscale         = g.ws;
    e.sack_perm_pres = g.sperm_en;
    e.sack_pres      = g.sack_en;
    e.sack_blocks    = g.sack_en ? g.sack_n : 3'd0;
    e.ts_pres        = g.ts_en;
    e.ts_val         = g.ts_val;
    e.ts_echo        = g.ts_echo;
    e.err            = g.len_err || g.bit_err || (g.offset < 4'd5);
    return e;
  endfunction

  task automatic compare_info(input tcp_seg_info_t got, input tcp_seg_info_t e);
    check_field("src_port", got.src_port, e.src_port);
    check_field("dst_port", got.dst_port, e.dst_port);
    check_field("seq_num", got.seq_num, e.seq_num);
    check_field("ack_num", got.ack_num, e.ack_num);
    check_field("flags", got.flags, e.flags);
    check_field("win_size", got.win_size, e.win_size);
    check_field("hdr_len", got.hdr_len, e.hdr_len);
    check_field("payload_len", got.payload_len, e.payload_len);
    check_field("mss_pres", got.mss_pres, e.mss_pres);
    if (e.mss_pres) check_field("mss", got.mss, e.mss);
    check_field("wscale_pres", got.wscale_pres, e.wscale_pres);
    if (e.wscale_pres) check_field("wscale", got.wscale, e.wscale);
    check_field("sack_perm_pres", got.sack_perm_pres, e.sack_perm_pres);
    check_field("sack_pres", got.sack_pres, e.sack_pres);
    check_field("sack_blocks", got.sack_blocks, e.sack_blocks);
    check_field("ts_pres", got.ts_pres, e.ts_pres);
    if (e.ts_pres) begin
      check_field("ts_val", got.ts_val, e.ts_val);
      check_field("ts_echo", got.ts_echo, e.ts_echo);
    end
    check_field("err", got.err, e.err);
  endtask

  // big endian with the msb byte first
  task automatic push_be(input logic [63:0] v, input int n);
    for (int i = n - 1; i >= 0; i--) seg_q.push_back(v[8*i +: 8]);
  endtask

  task automatic build_segment(input logic fill, output seg_gen_t g);
    int err_kind;
    int pay;
    g          = '0;
    seg_q      = {};
    err_kind   = fill ? 7 : take_bits(3);
    g.src_port = take_bits(16);
    g.dst_port = (fill || take_bits(2) != 0) ? LOCAL_PORT
                                             : LOCAL_PORT ^ {15'(take_bits(15)), 1'b1};
    g.seq_num  = take_bits(32);
    g.ack_num  = take_bits(32);
    g.flags    = take_bits(9);
    g.win_size = take_bits(16);
    push_be({g.src_port, g.dst_port, g.seq_num}, 8);
    push_be({g.ack_num, 8'h00, g.flags[7:0], g.win_size}, 8);
    // checksum and urgent pointer are not checked
    push_be(take_bits(32), 4);
    // no options when the offset is made too small
    if (!fill && err_kind != 2 && take_bits(2) != 0) begin
      g.mss_en   = take_bits(1);
      g.ws_en    = take_bits(1);
      g.sperm_en = take_bits(1);
      g.sack_en  = take_bits(1);
      g.ts_en    = take_bits(1);
    end
    if (g.mss_en) begin
      g.mss = take_bits(16);
      push_be({8'd2, 8'd4, g.mss}, 4);
    end
    if (g.ws_en) begin
      g.ws = take_bits(8);
      push_be({8'd1, 8'd3, 8'd3, g.ws}, 4);
    end
    if (g.sperm_en) push_be({8'd4, 8'd2}, 2);
    if (g.sack_en) begin
      g.sack_n = 3'd1 + 3'(take_bits(1));
      push_be({8'd5, 8'd2 + {2'd0, g.sack_n, 3'd0}}, 2);
      for (int i = 0; i < 8 * g.sack_n; i++) push_be(take_bits(8), 1);
    end
    if (g.ts_en) begin
      g.ts_val  = take_bits(32);
      g.ts_echo = take_bits(32);
      push_be({8'd8, 8'd10}, 2);
      push_be({g.ts_val, g.ts_echo}, 8);
    end
    while (seg_q.size() % 4 != 0) seg_q.push_back(8'd0);
    g.offset  = (err_kind == 2) ? 4'd1 + 4'(take_bits(2)) : 4'(seg_q.size() / 4);
    seg_q[12] = {g.offset, 3'b000, g.flags[8]};
    pay       = fill ? take_bits(2) : take_bits(5);
    for (int i = 0; i < pay; i++) push_be(take_bits(8), 1);
    g.len_err    = (err_kind == 0);
    g.bit_err    = (err_kind == 1);
    g.err_pos    = 16'(take_bits(6) % seg_q.size());
    g.stated_len = 16'(seg_q.size()) + (g.len_err ? 16'd1 + 16'(take_bits(2)) : 16'd0);
  endtask

  // called on a falling edge and returns on the one after the transfer
  task automatic send_beat(input tcp_byte_t b);
    in_beat  = b;
    in_valid = 1'b1;
    while (!in_ready) begin
      stall_cnt++;
      @(negedge clk);
    end
    @(negedge clk);
  endtask

  task automatic send_segment(input seg_gen_t g);
    tcp_byte_t b;
    for (int i = 0; i < seg_q.size(); i++) begin
      b         = '0;
      b.d       = seg_q[i];
      b.sof     = (i == 0);
      b.eof     = (i == seg_q.size() - 1);
      b.err     = g.bit_err && (i == g.err_pos);
      b.seg_len = (i == 0) ? g.stated_len : 16'd0;
      send_beat(b);
    end
    in_valid = 1'b0;
    in_beat  = '0;
    repeat (take_bits(2)) @(negedge clk);
  endtask

  task automatic wait_drain(input int max_cycles);
    int c;
    c = 0;
    while ((exp_q.size() != 0 || out_req || out_ack) && c < max_cycles) begin
      @(negedge clk);
      c++;
    end
  endtask

  initial begin
    seg_gen_t g;
    clk        = 1'b0;
    fsm_rst    = 1'b1;
    in_valid   = 1'b0;
    in_beat    = '0;
    local_port = LOCAL_PORT;
    out_ack    = 1'b0;
    slow_ack   = 1'b0;
    lfsr       = 16'd88;
    ack_lfsr   = 16'd88;
    stall_cnt  = 0;
    n_checked  = 0;
    repeat (3) @(negedge clk);
    fsm_rst = 1'b0;
    check_field("in_ready", in_ready, 1);
    check_field("out_req", out_req, 0);
    for (int s = 0; s < N_MIXED; s++) begin
      build_segment(1'b0, g);
      if (g.dst_port == local_port) exp_q.push_back(expect_info(g));
      send_segment(g);
    end
    wait_drain(2000);
    // short segments against slow acks so every lane fills
    slow_ack  = 1'b1;
    stall_cnt = 0;
    for (int s = 0; s < N_FILL; s++) begin
      build_segment(1'b1, g);
      exp_q.push_back(expect_info(g));
      send_segment(g);
    end
    wait_drain(4000);
    $display("%0d results checked", n_checked);
    if (exp_q.size() != 0 || out_req) begin
      $display("%0d expected results missing at the output", exp_q.size());
      $display("Finished with errors");
      $fatal(1);
    end else if (stall_cnt == 0) begin
      $display("in_ready never dropped while all lanes were full");
      $display("Finished with errors");
      $fatal(1);
    end else begin
      $display("Finished with no errors");
      $finish;
    end
  end

  // four-phase acknowledger with random delay
  initial begin : acknowledge
    int dly;
    forever begin
      @(negedge clk);
      if (out_req && !out_ack && !fsm_rst) begin
        dly = slow_ack ? 100 + ack_delay_bits(5) : ack_delay_bits(3);
        repeat (dly) @(negedge clk);
        out_ack = 1'b1;
        while (out_req) @(negedge clk);
        out_ack = 1'b0;
      end
    end
  end

  initial begin : compare
    tcp_seg_info_t e;
    logic          req_prev;
    req_prev = 1'b0;
    forever begin
      @(negedge clk);
      if (out_req && !req_prev) begin
        if (exp_q.size() == 0) begin
          $display("result presented at %0t ns with none expected", $time);
          $display("Finished with errors");
          $fatal(1);
        end else begin
          e = exp_q.pop_front();
          compare_info(out_info, e);
          n_checked++;
        end
      end
      req_prev = out_req;
    end
  end

  initial begin : watchdog
    repeat (200 * N_SEG) @(posedge clk);
    $display("timeout, the run did not complete in %0d cycles", 200 * N_SEG);
    $display("Finished with errors");
    $fatal(1);
  end

endmodule

`default_nettype wire

// File: source/tcp_rx_top.sv
`timescale 1ns/100ps
`default_nettype none

module tcp_rx_top (
  input  logic                      clk,
  input  logic                      fsm_rst,
  input  tcp_rx_pkg::tcp_byte_t     in_beat,
  input  logic                      in_valid,
  input  logic [15:0]               local_port,
  input  logic                      out_ack,
  output logic                      in_ready,
  output tcp_rx_pkg::tcp_seg_info_t out_info,
  output logic                      out_req
);
  import tcp_rx_pkg::*;

  tcp_byte_t             lane_beat [LANE_COUNT];
  logic [LANE_COUNT-1:0] lane_valid;
  logic [LANE_COUNT-1:0] lane_busy;
  tcp_seg_info_t         res_info [LANE_COUNT];
  logic [LANE_COUNT-1:0] res_hit;
  logic [LANE_COUNT-1:0] res_valid;
  logic [LANE_COUNT-1:0] res_take;

  tcp_seg_dispatch u_dispatch (
    .clk        (clk),
    .fsm_rst    (fsm_rst),
    .in_beat    (in_beat),
    .in_valid   (in_valid),
    .lane_busy  (lane_busy),
    .in_ready   (in_ready),
    .lane_beat  (lane_beat),
    .lane_valid (lane_valid)
  );

  // one parser per lane, filled and drained in the same rotation
  for (genvar i = 0; i < LANE_COUNT; i++) begin : g_lane
    tcp_hdr_parser u_parser (
      .clk        (clk),
      .fsm_rst    (fsm_rst),
      .beat       (lane_beat[i]),
      .valid      (lane_valid[i]),
      .local_port (local_port),
      .take       (res_take[i]),
      .busy       (lane_busy[i]),
      .info       (res_info[i]),
      .hit        (res_hit[i]),
      .info_valid (res_valid[i])
    );
  end

  tcp_result_collect u_collect (
    .clk       (clk),
    .fsm_rst   (fsm_rst),
    .res_info  (res_info),
    .res_hit   (res_hit),
    .res_valid (res_valid),
    .out_ack   (out_ack),
    .res_take  (res_take),
    .out_info  (out_info),
    .out_req   (out_req)
  );

endmodule

`default_nettype wire

// File: source/tcp_result_collect.sv
`timescale 1ns/100ps
`default_nettype none

module tcp_result_collect (
  input  logic                              clk,
  input  logic                              fsm_rst,
  input  tcp_rx_pkg::tcp_seg_info_t         res_info [tcp_rx_pkg::LANE_COUNT],
  input  logic [tcp_rx_pkg::LANE_COUNT-1:0] res_hit,
  input  logic [tcp_rx_pkg::LANE_COUNT-1:0] res_valid,
  input  logic                              out_ack,
  output logic [tcp_rx_pkg::LANE_COUNT-1:0] res_take,
  output tcp_rx_pkg::tcp_seg_info_t         out_info,
  output logic                              out_req
);
  import tcp_rx_pkg::*;

  // four-phase output handshake
  typedef enum logic [1:0] {
    idle,
    req_hi,
    wait_ack_lo
  } hs_state_e;

  hs_state_e             st;
  logic [LANE_IDX_W-1:0] ptr;
  logic [LANE_IDX_W-1:0] ptr_nxt;
  logic                  load;

  assign ptr_nxt = (ptr == LANE_IDX_W'(LANE_COUNT - 1)) ? '0 : ptr + 1'b1;
  assign load    = (st == idle) && res_valid[ptr] && res_hit[ptr];
  assign out_req = (st == req_hi);

  always_comb begin
    res_take = '0;
    case (st)
      // a port miss is dropped and the pointer moves on
      idle:    res_take[ptr] = res_valid[ptr] && !res_hit[ptr];
      req_hi:  res_take[ptr] = out_ack;
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      st  <= idle;
      ptr <= '0;
    end else begin
      case (st)
        idle: begin
          if (res_valid[ptr]) begin
            if (res_hit[ptr]) st <= req_hi;
            else ptr <= ptr_nxt;
          end
        end
        req_hi: begin
          if (out_ack) begin
            st  <= wait_ack_lo;
            ptr <= ptr_nxt;
          end
        end
        wait_ack_lo: begin
          if (!out_ack) st <= idle;
        end
        default: st <= idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (load) out_info <= res_info[ptr];
  end

  // the source lane holds the presented result until it is taken
  a_info_held: assert property (
    @(posedge clk) disable iff (fsm_rst)
    out_req |-> (res_valid[ptr] && (res_info[ptr] === out_info))
  );

endmodule

`default_nettype wire

// File: source/tcp_hdr_parser.sv
`timescale 1ns/100ps
`default_nettype none

module tcp_hdr_parser (
  input  logic                      clk,
  input  logic                      fsm_rst,
  input  tcp_rx_pkg::tcp_byte_t     beat,
  input  logic                      valid,
  input  logic [15:0]               local_port,
  input  logic                      take,
  output logic                      busy,
  output tcp_rx_pkg::tcp_seg_info_t info,
  output logic                      hit,
  output logic                      info_valid
);
  import tcp_rx_pkg::*;

  logic                        receiving;
  logic                        acc;
  logic [15:0]                 byte_cnt;
  logic [15:0]                 idx;
  logic [15:0]                 seg_len_q;
  logic [15:0]                 seg_len_cur;
  logic [MIN_HDR_LEN-2:0][7:0] hdr_sr;
  logic [MIN_HDR_LEN-1:0][7:0] hdr_word;
  logic                        hdr_last;
  logic [3:0]                  offset_q;
  logic [15:0]                 hdr_end;
  logic [15:0]                 dst_now;
  opt_state_e                  opt_st;
  opt_state_e                  opt_nxt;
  tcp_opt_kind_e               cur_kind;
  logic [7:0]                  opt_remain;
  logic [55:0]                 opt_sr;
  logic [63:0]                 opt_word;
  logic                        opt_active;
  logic                        opt_bad;
  logic                        opt_commit;
  logic                        err_q;
  logic                        err_now;

  assign acc         = valid && (receiving || beat.sof);
  assign idx         = beat.sof ? 16'd0 : byte_cnt;
  assign seg_len_cur = beat.sof ? beat.seg_len : seg_len_q;

  // byte 0 lands in the top element, the current byte in element 0
  assign hdr_word = {hdr_sr, beat.d};
  assign hdr_last = acc && (idx == 16'(MIN_HDR_LEN - 1));
  assign hdr_end  = {10'd0, offset_q, 2'b00};
  assign dst_now  = hdr_last ? {hdr_word[17], hdr_word[16]} : info.dst_port;
  assign opt_word = {opt_sr, beat.d};

  assign opt_active = acc && (idx >= 16'(MIN_HDR_LEN)) && (idx < hdr_end)
                      && (opt_st != opt_done);

  always_comb begin
    opt_nxt    = opt_st;
    opt_bad    = 1'b0;
    opt_commit = 1'b0;
    case (opt_st)
      opt_kind: begin
        case (beat.d)
          OPT_END: opt_nxt = opt_done;
          OPT_NOP: opt_nxt = opt_kind;
          default: begin
            // a kind needing a length on the last header byte
            if (idx == hdr_end - 16'd1) begin
              opt_bad = 1'b1;
              opt_nxt = opt_done;
            end else begin
              opt_nxt = opt_len;
            end
          end
        endcase
      end
      opt_len: begin
        // last option byte sits at idx + len - 2
        if ((beat.d < 8'd2) || (idx + {8'd0, beat.d} - 16'd2 >= hdr_end)) begin
          opt_bad = 1'b1;
          opt_nxt = opt_done;
        end else if (beat.d == 8'd2) begin
          opt_nxt = opt_kind;
        end else begin
          opt_nxt = opt_data;
        end
      end
      opt_data: begin
        if (opt_remain == 8'd1) begin
          opt_commit = 1'b1;
          opt_nxt    = opt_kind;
        end
      end
      default: ;
    endcase
  end

  assign err_now = acc && (beat.err
                   || (hdr_last && (offset_q < 4'd5))
                   || (opt_active && opt_bad)
                   || (beat.eof && ((idx + 16'd1 != seg_len_cur)
                                    || (idx < 16'(MIN_HDR_LEN - 1)))));

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      receiving  <= 1'b0;
      busy       <= 1'b0;
      info_valid <= 1'b0;
      err_q      <= 1'b0;
      opt_st     <= opt_done;
    end else begin
      if (take) begin
        busy       <= 1'b0;
        info_valid <= 1'b0;
      end
      if (acc) begin
        receiving <= !beat.eof;
        err_q     <= beat.sof ? err_now : (err_q || err_now);
        if (beat.sof) busy <= 1'b1;
        if (beat.eof) info_valid <= 1'b1;
        if (beat.sof) opt_st <= opt_done;
        else if (hdr_last) opt_st <= opt_kind;
        else if (opt_active) opt_st <= opt_nxt;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (acc) begin
      byte_cnt <= idx + 16'd1;
      if (beat.sof) begin
        seg_len_q           <= beat.seg_len;
        info.mss_pres       <= 1'b0;
        info.wscale_pres    <= 1'b0;
        info.sack_perm_pres <= 1'b0;
        info.sack_pres      <= 1'b0;
        info.sack_blocks    <= 3'd0;
        info.ts_pres        <= 1'b0;
      end
      if (idx < 16'(MIN_HDR_LEN - 1)) hdr_sr <= {hdr_sr[MIN_HDR_LEN-3:0], beat.d};
      if (idx == 16'(OFFSET_POS)) offset_q <= beat.d[7:4];
      if (hdr_last) begin
        info.src_port <= {hdr_word[19], hdr_word[18]};
        info.dst_port <= {hdr_word[17], hdr_word[16]};
        info.seq_num  <= hdr_word[15:12];
        info.ack_num  <= hdr_word[11:8];
        info.flags    <= {hdr_word[7][0], hdr_word[6]};
        info.win_size <= hdr_word[5:4];
      end
      if (opt_active) begin
        case (opt_st)
          opt_kind: begin
            cur_kind <= tcp_opt_kind_e'(beat.d);
            if (beat.d == OPT_SACK_PERM) info.sack_perm_pres <= 1'b1;
          end
          opt_len: begin
            opt_remain <= beat.d - 8'd2;
            // only presence and block count of SACK are kept
            if (cur_kind == OPT_SACK && !opt_bad) begin
              info.sack_pres   <= 1'b1;
              info.sack_blocks <= 3'((beat.d - 8'd2) >> 3);
            end
          end
          opt_data: begin
            opt_sr     <= opt_word[55:0];
            opt_remain <= opt_remain - 8'd1;
            if (opt_commit) begin
              case (cur_kind)
                OPT_MSS: begin
                  info.mss_pres <= 1'b1;
                  info.mss      <= opt_word[15:0];
                end
                OPT_WSCALE: begin
                  info.wscale_pres <= 1'b1;
                  info.wscale      <= opt_word[7:0];
                end
                OPT_TIMESTAMP: begin
                  info.ts_pres <= 1'b1;
                  info.ts_val  <= opt_word[63:32];
                  info.ts_echo <= opt_word[31:0];
                end
                default: ;
              endcase
            end
          end
          default: ;
        endcase
      end
      if (beat.eof) begin
        info.hdr_len     <= hdr_end[5:0];
        info.payload_len <= seg_len_cur - hdr_end;
        info.err         <= (err_q && !beat.sof) || err_now;
        hit              <= (dst_now == local_port);
      end
    end
  end

  // the dispatcher must wait for the drain before reusing this lane
  a_no_sof_on_result: assert property (
    @(posedge clk) disable iff (fsm_rst)
    (valid && beat.sof) |-> !info_valid
  );

endmodule

`default_nettype wire

// File: source/tcp_seg_dispatch.sv
`timescale 1ns/100ps
`default_nettype none

module tcp_seg_dispatch (
  input  logic                              clk,
  input  logic                              fsm_rst,
  input  tcp_rx_pkg::tcp_byte_t             in_beat,
  input  logic                              in_valid,
  input  logic [tcp_rx_pkg::LANE_COUNT-1:0] lane_busy,
  output logic                              in_ready,
  output tcp_rx_pkg::tcp_byte_t             lane_beat [tcp_rx_pkg::LANE_COUNT],
  output logic [tcp_rx_pkg::LANE_COUNT-1:0] lane_valid
);
  import tcp_rx_pkg::*;

  logic [LANE_IDX_W-1:0] ptr;
  logic [LANE_IDX_W-1:0] ptr_nxt;
  logic                  in_seg;
  logic                  xfer;

  assign ptr_nxt = (ptr == LANE_IDX_W'(LANE_COUNT - 1)) ? '0 : ptr + 1'b1;

  // between segments the next lane must be free before a sof may pass
  assign in_ready = in_seg || !lane_busy[ptr];
  assign xfer     = in_valid && in_ready;

  always_comb begin
    for (int i = 0; i < LANE_COUNT; i++) begin
      if (ptr == LANE_IDX_W'(i)) begin
        lane_beat[i]  = in_beat;
        lane_valid[i] = xfer;
      end else begin
        // idle lanes see a quiet bus
        lane_beat[i]  = '0;
        lane_valid[i] = 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      ptr    <= '0;
      in_seg <= 1'b0;
    end else if (xfer) begin
      if (in_beat.eof) begin
        // single-beat segments also move the pointer
        in_seg <= 1'b0;
        ptr    <= ptr_nxt;
      end else if (in_beat.sof) begin
        in_seg <= 1'b1;
      end
    end
  end

  // a lane still holding a result never gets a new segment
  a_no_sof_to_busy: assert property (
    @(posedge clk) disable iff (fsm_rst)
    (in_valid && in_beat.sof) |-> ((lane_valid & lane_busy) == '0)
  );

endmodule

`default_nettype wire

// File: source/tcp_rx_pkg.sv
`default_nettype none

package tcp_rx_pkg;

  // lane rotation
  localparam int LANE_COUNT = 4;
  localparam int LANE_IDX_W = 2;

  // fixed header geometry, bytes
  localparam int MIN_HDR_LEN = 20;
  localparam int OFFSET_POS  = 12;

  typedef enum logic [7:0] {
    OPT_END       = 8'd0,
    OPT_NOP       = 8'd1,
    OPT_MSS       = 8'd2,
    OPT_WSCALE    = 8'd3,
    OPT_SACK_PERM = 8'd4,
    OPT_SACK      = 8'd5,
    OPT_TIMESTAMP = 8'd8
  } tcp_opt_kind_e;

  // option walker, one byte per state step
  typedef enum logic [1:0] {
    opt_kind,
    opt_len,
    opt_data,
    opt_done
  } opt_state_e;

  // one byte of the TCP part of an IPv4 packet
  typedef struct packed {
    logic [7:0]  d;
    logic        sof;
    logic        eof;
    logic        err;
    // TCP length from the IPv4 header, valid with sof
    logic [15:0] seg_len;
  } tcp_byte_t;

  typedef struct packed {
    logic [15:0] src_port;
    logic [15:0] dst_port;
    logic [31:0] seq_num;
    logic [31:0] ack_num;
    // NS then CWR down to FIN
    logic [8:0]  flags;
    logic [15:0] win_size;
    logic [5:0]  hdr_len;
    logic [15:0] payload_len;
    logic        mss_pres;
    logic [15:0] mss;
    logic        wscale_pres;
    logic [7:0]  wscale;
    logic        sack_perm_pres;
    logic        sack_pres;
    logic [2:0]  sack_blocks;
    logic        ts_pres;
    logic [31:0] ts_val;
    logic [31:0] ts_echo;
    logic        err;
  } tcp_seg_info_t;

endpackage

`default_nettype wire
